/* flist.f */
+incdir+include
source/wisc_pkg.sv
source/data_mem.sv
source/execute_stage.sv
source/memory_stage.sv
source/writeback_stage.sv
source/wisc_mem_top.sv
tests/wb_checker.sv
tests/wisc_mem_tb.sv

/* include/wisc_config.svh */
// Shared sizing macros for the WISC back-end pipeline
//   data word width
//   data memory depth and word address width
`ifndef WISC_CONFIG_SVH
`define WISC_CONFIG_SVH

////////////////////////////////////////////////////////////
// Datapath
////////////////////////////////////////////////////////////

// One machine word
`define WISC_DATA_W 16

////////////////////////////////////////////////////////////
// Data memory
////////////////////////////////////////////////////////////

// Words in the data memory
`define WISC_MEM_DEPTH 256
// Word index bits, taken from byte address bits 8 down to 1
`define WISC_MEM_AW 8

`endif

/* run_sim.sh */
#!/bin/sh
# Build and run the WISC back-end testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module wisc_mem_tb -f flist.f -o wisc_mem_sim

status=0
./obj_dir/wisc_mem_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Done: errors found" sim.log; then
   echo "simulation FAILED"
   exit 1
fi
echo "simulation passed"

/* source/data_mem.sv */
// Data memory
//   single-port word array
//   write on enable with write strobe
//   registered read, held while idle
`timescale 1ns/1ps
`include "wisc_config.svh"

module data_mem (
   input  logic                    clk,
   input  logic                    en,
   input  logic                    wr,
   input  logic [`WISC_MEM_AW-1:0] addr,
   input  logic [`WISC_DATA_W-1:0] wdata,
   output logic [`WISC_DATA_W-1:0] rdata
);

   // Storage array, contents undefined until written
   logic [`WISC_DATA_W-1:0] mem [`WISC_MEM_DEPTH];

   ////////////////////////////////////////////////////////////
   // Access port
   ////////////////////////////////////////////////////////////

   // Write takes the port for the cycle
   always_ff @(posedge clk) begin
      if (en && wr) begin
         mem[addr] <= wdata;
      end
   end

   // Read data lands at the same edge as the address
   // Last word stays on rdata between reads
   always_ff @(posedge clk) begin
      if (en && !wr) begin
         rdata <= mem[addr];
      end
   end

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////

   // Controller must never strobe a write on a disabled port
   a_wr_needs_en: assert property (@(posedge clk)
      wr |-> en);

endmodule

/* source/execute_stage.sv */
// Execute stage
//   opcode and immediate decode
//   ALU and address adder
//   execute/memory pipeline latch
`timescale 1ns/1ps
`include "wisc_config.svh"

module execute_stage
   import wisc_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    in_valid,
   input  logic [`WISC_DATA_W-1:0] instruction,
   input  logic [`WISC_DATA_W-1:0] incr_pc,
   input  logic [`WISC_DATA_W-1:0] a_value,
   input  logic [`WISC_DATA_W-1:0] b_value,
   output logic                    ex_valid,
   output logic [`WISC_DATA_W-1:0] ex_instruction,
   output logic [`WISC_DATA_W-1:0] ex_incr_pc,
   output logic [`WISC_DATA_W-1:0] ex_b_value,
   output logic [`WISC_DATA_W-1:0] ex_result
);

   opcode_e                 opcode;
   logic [4:0]              imm5;
   logic [`WISC_DATA_W-1:0] imm_sext;
   logic [`WISC_DATA_W-1:0] imm_zext;
   logic [1:0]              funct;
   logic [`WISC_DATA_W-1:0] alu_result;
   logic                    op_supported;

   ////////////////////////////////////////////////////////////
   // Decode
   ////////////////////////////////////////////////////////////

   assign opcode   = opcode_e'(instruction[15:11]);
   assign imm5     = instruction[4:0];
   // Arithmetic immediates are signed
   assign imm_sext = {{(`WISC_DATA_W-5){imm5[4]}}, imm5};
   // Logic immediates are unsigned
   assign imm_zext = {{(`WISC_DATA_W-5){1'b0}}, imm5};
   // R-format function select
   assign funct    = instruction[1:0];

   ////////////////////////////////////////////////////////////
   // ALU
   ////////////////////////////////////////////////////////////

   always_comb begin
      alu_result   = '0;
      op_supported = 1'b1;
      case (opcode)
         // Address is rs plus offset for all memory ops
         OP_ADDI, OP_ST, OP_LD, OP_STU: alu_result = a_value + imm_sext;
         // Immediate minus rs
         OP_SUBI:  alu_result = imm_sext - a_value;
         OP_XORI:  alu_result = a_value ^ imm_zext;
         OP_ANDNI: alu_result = a_value & ~imm_zext;
         OP_RTYPE: begin
            case (funct)
               2'b00:   alu_result = a_value + b_value;
               // Rt minus rs
               2'b01:   alu_result = b_value - a_value;
               2'b10:   alu_result = a_value ^ b_value;
               default: alu_result = a_value & ~b_value;
            endcase
         end
         // Result unused downstream
         OP_JAL, OP_NOP: alu_result = '0;
         default: op_supported = 1'b0;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Execute/memory latch
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ex_valid <= 1'b0;
      end else begin
         ex_valid <= in_valid;
      end
   end

   // Payload only follows valid items
   always_ff @(posedge clk) begin
      if (in_valid) begin
         ex_instruction <= instruction;
         ex_incr_pc     <= incr_pc;
         ex_b_value     <= b_value;
         ex_result      <= alu_result;
      end
   end

   // Upstream never issues an opcode outside the back-end subset
   a_supported_op: assert property (@(posedge clk) disable iff (!rst_n)
      in_valid |-> op_supported);

endmodule

/* source/memory_stage.sv */
// Memory stage
//   memory control decode from the opcode
//   data memory instance
//   memory/writeback pipeline latch
`timescale 1ns/1ps
`include "wisc_config.svh"

module memory_stage
   import wisc_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    ex_valid,
   input  logic [`WISC_DATA_W-1:0] ex_instruction,
   input  logic [`WISC_DATA_W-1:0] ex_incr_pc,
   input  logic [`WISC_DATA_W-1:0] ex_b_value,
   input  logic [`WISC_DATA_W-1:0] ex_result,
   output logic                    mem_valid,
   output logic [`WISC_DATA_W-1:0] mem_instruction,
   output logic [`WISC_DATA_W-1:0] mem_incr_pc,
   output logic [`WISC_DATA_W-1:0] mem_result,
   output logic [`WISC_DATA_W-1:0] mem_read_data
);

   opcode_e                 opcode;
   logic                    mem_en;
   logic                    mem_wr;
   logic [`WISC_MEM_AW-1:0] word_addr;

   ////////////////////////////////////////////////////////////
   // Memory control
   ////////////////////////////////////////////////////////////

   assign opcode = opcode_e'(ex_instruction[15:11]);

   // Memory group is prefix 100, low bits 10 unused
   assign mem_en = ex_valid && (opcode[4:2] == 3'b100) && (opcode[1:0] != 2'b10);
   // ST and STU have equal low bits
   assign mem_wr = ex_valid && (opcode[4:2] == 3'b100) && ~^opcode[1:0];

   // Byte address to word index
   assign word_addr = ex_result[`WISC_MEM_AW:1];

   // Read data is registered inside, so it lines up with the latch below
   data_mem u_data_mem (
      .clk   (clk),
      .en    (mem_en),
      .wr    (mem_wr),
      .addr  (word_addr),
      .wdata (ex_b_value),
      .rdata (mem_read_data)
   );

   ////////////////////////////////////////////////////////////
   // Memory/writeback latch
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         mem_valid <= 1'b0;
      end else begin
         mem_valid <= ex_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (ex_valid) begin
         mem_instruction <= ex_instruction;
         mem_incr_pc     <= ex_incr_pc;
         mem_result      <= ex_result;
      end
   end

   // Execute must hand over a clean address for any access
   a_addr_known: assert property (@(posedge clk) disable iff (!rst_n)
      mem_en |-> !$isunknown(word_addr));

endmodule

/* source/wisc_mem_top.sv */
// Back-end pipeline top
//   execute, memory and writeback stages in chain
//   register write presented at the ports
`timescale 1ns/1ps
`include "wisc_config.svh"

module wisc_mem_top (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    in_valid,
   input  logic [`WISC_DATA_W-1:0] instruction,
   input  logic [`WISC_DATA_W-1:0] incr_pc,
   input  logic [`WISC_DATA_W-1:0] a_value,
   input  logic [`WISC_DATA_W-1:0] b_value,
   output logic                    wb_en,
   output logic [2:0]              wb_reg,
   output logic [`WISC_DATA_W-1:0] wb_data
);

   // Execute to memory
   logic                    ex_valid;
   logic [`WISC_DATA_W-1:0] ex_instruction;
   logic [`WISC_DATA_W-1:0] ex_incr_pc;
   logic [`WISC_DATA_W-1:0] ex_b_value;
   logic [`WISC_DATA_W-1:0] ex_result;

   // Memory to writeback
   logic                    mem_valid;
   logic [`WISC_DATA_W-1:0] mem_instruction;
   logic [`WISC_DATA_W-1:0] mem_incr_pc;
   logic [`WISC_DATA_W-1:0] mem_result;
   logic [`WISC_DATA_W-1:0] mem_read_data;

   ////////////////////////////////////////////////////////////
   // Stage chain
   ////////////////////////////////////////////////////////////

   execute_stage u_execute (
      .clk            (clk),
      .rst_n          (rst_n),
      .in_valid       (in_valid),
      .instruction    (instruction),
      .incr_pc        (incr_pc),
      .a_value        (a_value),
      .b_value        (b_value),
      .ex_valid       (ex_valid),
      .ex_instruction (ex_instruction),
      .ex_incr_pc     (ex_incr_pc),
      .ex_b_value     (ex_b_value),
      .ex_result      (ex_result)
   );

   memory_stage u_memory (
      .clk             (clk),
      .rst_n           (rst_n),
      .ex_valid        (ex_valid),
      .ex_instruction  (ex_instruction),
      .ex_incr_pc      (ex_incr_pc),
      .ex_b_value      (ex_b_value),
      .ex_result       (ex_result),
      .mem_valid       (mem_valid),
      .mem_instruction (mem_instruction),
      .mem_incr_pc     (mem_incr_pc),
      .mem_result      (mem_result),
      .mem_read_data   (mem_read_data)
   );

   // Combinational, so the write shows in the cycle after the memory edge
   writeback_stage u_writeback (
      .mem_valid       (mem_valid),
      .mem_instruction (mem_instruction),
      .mem_incr_pc     (mem_incr_pc),
      .mem_result      (mem_result),
      .mem_read_data   (mem_read_data),
      .wb_en           (wb_en),
      .wb_reg          (wb_reg),
      .wb_data         (wb_data)
   );

endmodule

/* source/wisc_pkg.sv */
// WISC pipeline types
//   opcode_e   5-bit major opcodes handled by the back end
//   wb_src_e   writeback value source
package wisc_pkg;

   ////////////////////////////////////////////////////////////
   // Opcodes
   ////////////////////////////////////////////////////////////

   // Instruction bits 15 to 11
   typedef enum logic [4:0] {
      // No operation
      OP_NOP   = 5'b00001,
      // Memory group, prefix 100
      OP_ST    = 5'b10000,
      OP_LD    = 5'b10001,
      OP_STU   = 5'b10011,
      // I-format ALU ops
      OP_ADDI  = 5'b01000,
      OP_SUBI  = 5'b01001,
      OP_XORI  = 5'b01010,
      OP_ANDNI = 5'b01011,
      // ADD, SUB, XOR, ANDN picked by function bits 1 to 0
      OP_RTYPE = 5'b11011,
      // Jump and link, only the link write is modeled
      OP_JAL   = 5'b00110
   } opcode_e;

   ////////////////////////////////////////////////////////////
   // Writeback source
   ////////////////////////////////////////////////////////////

   typedef enum logic [1:0] {
      // Execute result
      WB_ALU  = 2'd0,
      // Data memory read
      WB_MEM  = 2'd1,
      // Incremented PC for the link
      WB_PC   = 2'd2,
      // No register write
      WB_NONE = 2'd3
   } wb_src_e;

endpackage

/* source/writeback_stage.sv */
// Writeback stage
//   source classification per opcode
//   destination register select
//   write data mux and write enable
`timescale 1ns/1ps
`include "wisc_config.svh"

module writeback_stage
   import wisc_pkg::*;
(
   input  logic                    mem_valid,
   input  logic [`WISC_DATA_W-1:0] mem_instruction,
   input  logic [`WISC_DATA_W-1:0] mem_incr_pc,
   input  logic [`WISC_DATA_W-1:0] mem_result,
   input  logic [`WISC_DATA_W-1:0] mem_read_data,
   output logic                    wb_en,
   output logic [2:0]              wb_reg,
   output logic [`WISC_DATA_W-1:0] wb_data
);

   opcode_e opcode;
   wb_src_e wb_src;

   assign opcode = opcode_e'(mem_instruction[15:11]);

   ////////////////////////////////////////////////////////////
   // Source and destination
   ////////////////////////////////////////////////////////////

   always_comb begin
      wb_src = WB_NONE;
      wb_reg = 3'd0;
      case (opcode)
         OP_LD: begin
            wb_src = WB_MEM;
            wb_reg = mem_instruction[7:5];
         end
         OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI: begin
            wb_src = WB_ALU;
            wb_reg = mem_instruction[7:5];
         end
         // Updated address goes back to the base register
         OP_STU: begin
            wb_src = WB_ALU;
            wb_reg = mem_instruction[10:8];
         end
         OP_RTYPE: begin
            wb_src = WB_ALU;
            wb_reg = mem_instruction[4:2];
         end
         // Link register is fixed at r7
         OP_JAL: begin
            wb_src = WB_PC;
            wb_reg = 3'd7;
         end
         // ST, NOP and anything else write nothing
         default: wb_src = WB_NONE;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Write data
   ////////////////////////////////////////////////////////////

   always_comb begin
      case (wb_src)
         WB_ALU:  wb_data = mem_result;
         WB_MEM:  wb_data = mem_read_data;
         WB_PC:   wb_data = mem_incr_pc;
         default: wb_data = '0;
      endcase
   end

   assign wb_en = mem_valid && (wb_src != WB_NONE);

endmodule

/* tests/wb_checker.sv */
// Writeback checker for the WISC back end
//   reference model of the register write
//   model data memory with written flags
//   two-edge expected queue and comparison
`timescale 1ns/1ps
`include "wisc_config.svh"

module wb_checker
   import wisc_pkg::*;
(
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    in_valid,
   input  logic [`WISC_DATA_W-1:0] instruction,
   input  logic [`WISC_DATA_W-1:0] incr_pc,
   input  logic [`WISC_DATA_W-1:0] a_value,
   input  logic [`WISC_DATA_W-1:0] b_value,
   input  logic                    wb_en,
   input  logic [2:0]              wb_reg,
   input  logic [`WISC_DATA_W-1:0] wb_data,
   output int                      error_count,
   output int                      check_count
);

   // One expected writeback slot
   typedef struct packed {
      logic                    en;
      logic [2:0]              dst;
      logic [`WISC_DATA_W-1:0] data;
      logic                    data_known;
   } wb_exp_t;

   logic [`WISC_DATA_W-1:0]    model_mem [`WISC_MEM_DEPTH];
   // Words never stored give no data compare
   logic [`WISC_MEM_DEPTH-1:0] model_known = '0;
   wb_exp_t                    exp_q [$];
   int                         errors = 0;
   int                         checks = 0;

   assign error_count = errors;
   assign check_count = checks;

   ////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////

   function automatic logic [`WISC_DATA_W-1:0] sext_imm5(
      input logic [`WISC_DATA_W-1:0] instr
   );
      return {{(`WISC_DATA_W-5){instr[4]}}, instr[4:0]};
   endfunction

   // Byte address to word index, bits 8 down to 1
   function automatic logic [`WISC_MEM_AW-1:0] word_index(
      input logic [`WISC_DATA_W-1:0] addr
   );
      return addr[`WISC_MEM_AW:1];
   endfunction

   // Expected register write for one accepted instruction
   function automatic wb_exp_t predict_write(
      input logic [`WISC_DATA_W-1:0] instr,
      input logic [`WISC_DATA_W-1:0] rs_val,
      input logic [`WISC_DATA_W-1:0] rt_val,
      input logic [`WISC_DATA_W-1:0] pc
   );
      wb_exp_t                 e;
      wb_src_e                 src;
      logic [`WISC_DATA_W-1:0] simm;
      logic [`WISC_DATA_W-1:0] uimm;
      logic [`WISC_DATA_W-1:0] value;
      simm         = sext_imm5(instr);
      uimm         = {{(`WISC_DATA_W-5){1'b0}}, instr[4:0]};
      // Address and ADDI share rs plus signed imm
      value        = rs_val + simm;
      src          = WB_ALU;
      e            = '0;
      e.data_known = 1'b1;
      case (opcode_e'(instr[15:11]))
         OP_LD: begin
            src   = WB_MEM;
            e.dst = instr[7:5];
         end
         OP_ADDI: e.dst = instr[7:5];
         OP_SUBI: begin
            value = simm - rs_val;
            e.dst = instr[7:5];
         end
         OP_XORI: begin
            value = rs_val ^ uimm;
            e.dst = instr[7:5];
         end
         OP_ANDNI: begin
            value = rs_val & ~uimm;
            e.dst = instr[7:5];
         end
         // Base register gets the new address
         OP_STU: e.dst = instr[10:8];
         OP_RTYPE: begin
            e.dst = instr[4:2];
            case (instr[1:0])
               2'b00:   value = rs_val + rt_val;
               2'b01:   value = rt_val - rs_val;
               2'b10:   value = rs_val ^ rt_val;
               default: value = rs_val & ~rt_val;
            endcase
         end
         OP_JAL: begin
            src   = WB_PC;
            e.dst = 3'd7;
         end
         default: src = WB_NONE;
      endcase
      case (src)
         WB_MEM: begin
            e.data       = model_mem[word_index(value)];
            e.data_known = model_known[word_index(value)];
         end
         WB_PC:   e.data = pc;
         default: e.data = value;
      endcase
      e.en = (src != WB_NONE);
      return e;
   endfunction

   ////////////////////////////////////////////////////////////
   // Comparison
   ////////////////////////////////////////////////////////////

   task automatic compare_write(input wb_exp_t due);
      checks++;
      if (wb_en !== due.en) begin
         errors++;
         if (due.en) begin
            $display("time %0t: expected write to r%0d did not appear", $time, due.dst);
         end else begin
            $display("time %0t: unexpected register write to r%0d with %h",
               $time, wb_reg, wb_data);
         end
      end else if (due.en) begin
         if (wb_reg !== due.dst) begin
            errors++;
            $display("mismatch at time %0t: wb_reg expected %0d actual %0d",
               $time, due.dst, wb_reg);
         end
         if (due.data_known && (wb_data !== due.data)) begin
            errors++;
            $display("mismatch at time %0t: wb_data expected %h actual %h",
               $time, due.data, wb_data);
         end
      end
   endtask

   // Sample at each edge, outputs seen here belong to the item two edges back
   always @(posedge clk) begin : sample_and_compare
      wb_exp_t                 fresh;
      wb_exp_t                 due;
      logic [`WISC_DATA_W-1:0] addr;
      fresh = '0;
      if (rst_n && in_valid) begin
         fresh = predict_write(instruction, a_value, b_value, incr_pc);
         addr  = a_value + sext_imm5(instruction);
         // Stores land after the prediction, program order kept
         if (opcode_e'(instruction[15:11]) inside {OP_ST, OP_STU}) begin
            model_mem[word_index(addr)]   = b_value;
            model_known[word_index(addr)] = 1'b1;
         end
      end
      if (exp_q.size() == 2) begin
         due = exp_q.pop_front();
         if (rst_n) begin
            compare_write(due);
         end
      end
      exp_q.push_back(fresh);
   end

endmodule

/* tests/wisc_mem_tb.sv */
// Testbench for the WISC back-end pipeline
//   clock, reset and watchdog
//   directed and random instruction stimulus
//   UUT and writeback checker instances
`timescale 1ns/1ps
`include "wisc_config.svh"

module wisc_mem_tb
   import wisc_pkg::*;
();

   localparam int CLK_PERIOD   = 20;
   localparam int RESET_CYCLES = 4;
   localparam int NUM_ALU      = 40;
   localparam int NUM_MIXED    = 200;
   // Directed phases plus drain
   localparam int NUM_DIRECTED = 30;
   localparam int NUM_SLOTS    = NUM_ALU + NUM_MIXED + NUM_DIRECTED;

   logic                    clk;
   logic                    rst_n;
   logic                    in_valid;
   logic [`WISC_DATA_W-1:0] instruction;
   logic [`WISC_DATA_W-1:0] incr_pc;
   logic [`WISC_DATA_W-1:0] a_value;
   logic [`WISC_DATA_W-1:0] b_value;
   logic                    wb_en;
   logic [2:0]              wb_reg;
   logic [`WISC_DATA_W-1:0] wb_data;
   int                      error_count;
   int                      check_count;
   integer                  seed = 32'he434_56e4;
   logic [`WISC_DATA_W-1:0] pc;

   wisc_mem_top UUT (
      .clk         (clk),
      .rst_n       (rst_n),
      .in_valid    (in_valid),
      .instruction (instruction),
      .incr_pc     (incr_pc),
      .a_value     (a_value),
      .b_value     (b_value),
      .wb_en       (wb_en),
      .wb_reg      (wb_reg),
      .wb_data     (wb_data)
   );

   wb_checker u_checker (
      .clk         (clk),
      .rst_n       (rst_n),
      .in_valid    (in_valid),
      .instruction (instruction),
      .incr_pc     (incr_pc),
      .a_value     (a_value),
      .b_value     (b_value),
      .wb_en       (wb_en),
      .wb_reg      (wb_reg),
      .wb_data     (wb_data),
      .error_count (error_count),
      .check_count (check_count)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   ////////////////////////////////////////////////////////////
   // Instruction builders and drivers
   ////////////////////////////////////////////////////////////

   function automatic logic [`WISC_DATA_W-1:0] i_format(
      input opcode_e op, input logic [2:0] rs, input logic [2:0] rd, input logic [4:0] imm
   );
      return {op, rs, rd, imm};
   endfunction

   function automatic logic [`WISC_DATA_W-1:0] r_format(
      input logic [2:0] rs, input logic [2:0] rt, input logic [2:0] rd, input logic [1:0] fn
   );
      return {OP_RTYPE, rs, rt, rd, fn};
   endfunction

   function automatic opcode_e i_alu_op(input logic [1:0] sel);
      case (sel)
         2'd0:    return OP_ADDI;
         2'd1:    return OP_SUBI;
         2'd2:    return OP_XORI;
         default: return OP_ANDNI;
      endcase
   endfunction

   // One slot, driven on the falling edge
   task automatic issue(
      input logic                    valid,
      input logic [`WISC_DATA_W-1:0] instr,
      input logic [`WISC_DATA_W-1:0] rs_val,
      input logic [`WISC_DATA_W-1:0] rt_val
   );
      @(negedge clk);
      pc          = pc + 16'd2;
      in_valid    = valid;
      instruction = instr;
      incr_pc     = pc;
      a_value     = rs_val;
      b_value     = rt_val;
   endtask

   // Junk payload, must be ignored
   task automatic idle_cycle();
      issue(1'b0, 16'($random(seed)), 16'($random(seed)), 16'($random(seed)));
   endtask

   task automatic random_alu();
      logic [31:0]             pick;
      logic [`WISC_DATA_W-1:0] instr;
      pick = $random(seed);
      if (pick[31]) begin
         instr = r_format(pick[10:8], pick[7:5], pick[4:2], pick[1:0]);
      end else begin
         instr = i_format(i_alu_op(pick[17:16]), pick[10:8], pick[7:5], pick[4:0]);
      end
      issue(1'b1, instr, 16'($random(seed)), 16'($random(seed)));
   endtask

   task automatic random_mixed();
      logic [31:0]             pick;
      logic [`WISC_DATA_W-1:0] base;
      pick = $random(seed);
      // Small aligned window so loads often hit stored words
      base = 16'($random(seed)) & 16'h003e;
      if (pick[31:30] == 2'd0) begin
         idle_cycle();
      end else begin
         case (pick[29:27])
            3'd3: issue(1'b1, i_format(OP_ST, pick[10:8], pick[7:5], pick[4:0]),
               base, 16'($random(seed)));
            3'd4, 3'd5: issue(1'b1, i_format(OP_LD, pick[10:8], pick[7:5], pick[4:0]),
               base, 16'($random(seed)));
            3'd6: issue(1'b1, i_format(OP_STU, pick[10:8], pick[7:5], pick[4:0]),
               base, 16'($random(seed)));
            3'd7: issue(1'b1, {(pick[26] ? OP_JAL : OP_NOP), pick[10:0]},
               16'($random(seed)), 16'($random(seed)));
            default: random_alu();
         endcase
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////

   initial begin
      rst_n       = 1'b0;
      in_valid    = 1'b0;
      instruction = '0;
      incr_pc     = '0;
      a_value     = '0;
      b_value     = '0;
      pc          = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      // Quiet start, then a store and a NOP that write nothing
      repeat (3) idle_cycle();
      issue(1'b1, i_format(OP_ST, 3'd1, 3'd2, 5'd0), 16'h0010, 16'h0bad);
      issue(1'b1, {OP_NOP, 11'd0}, '0, '0);
      repeat (2) idle_cycle();
      repeat (NUM_ALU) random_alu();
      // Store, reload, back-to-back load
      issue(1'b1, i_format(OP_ST, 3'd1, 3'd2, 5'd4), 16'h0020, 16'hbeef);
      issue(1'b1, i_format(OP_LD, 3'd1, 3'd3, 5'd4), 16'h0020, '0);
      issue(1'b1, i_format(OP_LD, 3'd1, 3'd4, 5'd4), 16'h0020, '0);
      // Negative offset
      issue(1'b1, i_format(OP_ST, 3'd2, 3'd6, 5'h1e), 16'h0040, 16'h1234);
      issue(1'b1, i_format(OP_LD, 3'd2, 3'd1, 5'h1e), 16'h0040, '0);
      issue(1'b1, i_format(OP_LD, 3'd1, 3'd2, 5'd4), 16'h0020, '0);
      // STU writes the address back to rs
      issue(1'b1, i_format(OP_STU, 3'd5, 3'd3, 5'd2), 16'h0060, 16'ha5a5);
      issue(1'b1, i_format(OP_LD, 3'd5, 3'd0, 5'd0), 16'h0062, '0);
      repeat (2) idle_cycle();
      // Link writes and non-writers
      issue(1'b1, {OP_JAL, 11'h123}, '0, '0);
      issue(1'b1, i_format(OP_ST, 3'd0, 3'd7, 5'd8), 16'h0000, 16'h7777);
      issue(1'b1, {OP_NOP, 11'h7ff}, '0, '0);
      idle_cycle();
      issue(1'b1, {OP_JAL, 11'h001}, '0, '0);
      repeat (NUM_MIXED) random_mixed();
      // Drain the pipeline
      repeat (4) idle_cycle();
      @(negedge clk);
      $display("checks: %0d  errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

   // Watchdog sized from the stimulus length
   initial begin
      #((NUM_SLOTS + 20) * CLK_PERIOD);
      $display("timeout: watchdog ended the run before the stimulus finished");
      $display("Done: errors found");
      $finish;
   end

endmodule
